// ==== hw/mipsPkg.sv ====
// MIPS subset shared definitions
// widths, opcode and funct encodings, ALU command set and the
// packed instruction and control views used across the core

package mipsPkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int dataWidth     = 32;
  localparam int regAddrWidth  = 5;
  localparam int dmemAddrWidth = 7;
  // jal link register index
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ==================================================
  // encodings
  // ==================================================
  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    opR   = 6'h00,
    opJ   = 6'h02,
    opJal = 6'h03,
    opBeq = 6'h04,
    opLw  = 6'h23,
    opSw  = 6'h2b
  } opcode_t;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } funct_t;

  // operation class from the main decoder
  typedef enum logic [1:0] {
    aluAdd   = 2'b00,
    aluSub   = 2'b01,
    aluFunct = 2'b10
  } aluOp_t;

  // ALU command
  typedef enum logic [3:0] {
    aluCtlAnd = 4'b0000,
    aluCtlOr  = 4'b0001,
    aluCtlAdd = 4'b0010,
    aluCtlSub = 4'b0110,
    aluCtlSlt = 4'b0111,
    aluCtlBad = 4'b1111
  } aluCtrl_t;

  // ==================================================
  // bundles
  // ==================================================
  // low 16 bits are the immediate, low 26 the jump target
  typedef struct packed {
    opcode_t                 op;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              shamt;
    funct_t                  funct;
  } instr_t;

  typedef struct packed {
    logic     regDst;
    logic     aluSrc;
    logic     memToReg;
    logic     regWrite;
    logic     memWrite;
    logic     branch;
    logic     jump;
    logic     link;
    aluOp_t   aluOp;
    aluCtrl_t aluCtrl;
  } ctrl_t;

endpackage

// ==== hw/mipsControl.sv ====
// MIPS main decoder and ALU control
// turns opcode and funct into the datapath control bundle

module mipsControl (
  input  mipsPkg::instr_t instr,
  output mipsPkg::ctrl_t  ctrl
);

  // ==================================================
  // main decode
  // ==================================================
  always_comb begin
    // safe default, nothing written
    ctrl          = '0;
    ctrl.aluOp    = mipsPkg::aluAdd;
    ctrl.aluCtrl  = mipsPkg::aluCtlBad;

    case (instr.op)
      mipsPkg::opR: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = mipsPkg::aluFunct;
      end
      mipsPkg::opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        // compare by subtraction
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ: begin
        ctrl.jump = 1'b1;
      end
      mipsPkg::opJal: begin
        // PC+4 into r31, no delay slot
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode, leave the defaults
        ctrl.aluOp = mipsPkg::aluAdd;
      end
    endcase

    // ALU command from class and funct
    case (ctrl.aluOp)
      mipsPkg::aluAdd: ctrl.aluCtrl = mipsPkg::aluCtlAdd;
      mipsPkg::aluSub: ctrl.aluCtrl = mipsPkg::aluCtlSub;
      mipsPkg::aluFunct: begin
        case (instr.funct)
          mipsPkg::fnAdd: ctrl.aluCtrl = mipsPkg::aluCtlAdd;
          mipsPkg::fnSub: ctrl.aluCtrl = mipsPkg::aluCtlSub;
          mipsPkg::fnAnd: ctrl.aluCtrl = mipsPkg::aluCtlAnd;
          mipsPkg::fnOr:  ctrl.aluCtrl = mipsPkg::aluCtlOr;
          mipsPkg::fnSlt: ctrl.aluCtrl = mipsPkg::aluCtlSlt;
          default:        ctrl.aluCtrl = mipsPkg::aluCtlBad;
        endcase
      end
      default: ctrl.aluCtrl = mipsPkg::aluCtlBad;
    endcase

    // bad funct kills any write
    if (ctrl.aluCtrl == mipsPkg::aluCtlBad) begin
      ctrl.regWrite = 1'b0;
      ctrl.memWrite = 1'b0;
    end
  end

  // a store never writes back
  always_comb begin
    assert final (!(ctrl.regWrite && ctrl.memWrite))
      else $error("regWrite and memWrite both set for op %h", instr.op);
  end

endmodule

// ==== hw/mipsAlu.sv ====
// MIPS ALU
// add, sub, and, or and signed slt with a zero flag

module mipsAlu (
  input  logic [mipsPkg::dataWidth-1:0] a,
  input  logic [mipsPkg::dataWidth-1:0] b,
  input  mipsPkg::aluCtrl_t             op,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      mipsPkg::aluCtlAdd: result = a + b;
      mipsPkg::aluCtlSub: result = a - b;
      mipsPkg::aluCtlAnd: result = a & b;
      mipsPkg::aluCtlOr:  result = a | b;
      // 1 or 0 in the low bit
      mipsPkg::aluCtlSlt: result = {{(mipsPkg::dataWidth-1){1'b0}}, lessThan};
      // unknown command gives 0
      default:            result = '0;
    endcase
  end

  // beq takes this, for any command
  assign zero = (result == '0);

endmodule

// ==== hw/mipsRegFile.sv ====
// MIPS register file
// 32 x 32, two combinational read ports, one write port,
// register 0 hardwired to zero

module mipsRegFile (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             we,
  input  logic [mipsPkg::regAddrWidth-1:0] waddr,
  input  logic [mipsPkg::regAddrWidth-1:0] raddr1,
  input  logic [mipsPkg::regAddrWidth-1:0] raddr2,
  input  logic [mipsPkg::dataWidth-1:0]    wdata,
  output logic [mipsPkg::dataWidth-1:0]    rdata1,
  output logic [mipsPkg::dataWidth-1:0]    rdata2
);

  localparam int numRegs = 2 ** mipsPkg::regAddrWidth;

  logic [mipsPkg::dataWidth-1:0] regs [numRegs];

  // write on the edge, never into r0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // reads see the old value during a write cycle
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // r0 holds zero across every cycle
  assert property (@(posedge clk) disable iff (!rst) regs[0] == '0)
    else $error("register 0 was written");

endmodule

// ==== hw/mipsPc.sv ====
// MIPS program counter
// sequential, beq and j/jal next-address selection

module mipsPc (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          branch,
  input  logic                          jump,
  input  logic                          zero,
  input  logic [mipsPkg::dataWidth-1:0] imm,
  input  logic [25:0]                   target,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] pcPlus4
);

  logic [mipsPkg::dataWidth-1:0] branchAddr;
  logic [mipsPkg::dataWidth-1:0] jumpAddr;
  logic [mipsPkg::dataWidth-1:0] pcNext;

  assign pcPlus4 = pc + 32'd4;

  // word offset relative to PC+4
  assign branchAddr = pcPlus4 + {imm[mipsPkg::dataWidth-3:0], 2'b00};

  // region bits kept from PC+4
  assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

  // jump wins over a taken branch
  always_comb begin
    if (jump) begin
      pcNext = jumpAddr;
    end else if (branch && zero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // fetch address stays on a word boundary
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

// ==== hw/mipsCore.sv ====
// single-cycle MIPS core
// add, sub, and, or, slt, lw, sw, beq, j and jal, one per clock
// instruction and data memories are external, read combinationally

module mipsCore (
  input  logic                              clk,
  input  logic                              rst,
  output logic [mipsPkg::dataWidth-1:0]     imemAddr,
  input  logic [mipsPkg::dataWidth-1:0]     imemData,
  output logic [mipsPkg::dmemAddrWidth-1:0] dmemAddr,
  output logic [mipsPkg::dataWidth-1:0]     dmemWData,
  output logic                              dmemWen,
  input  logic [mipsPkg::dataWidth-1:0]     dmemRData,
  output logic [mipsPkg::dataWidth-1:0]     rfWriteData,
  output logic                              rfWriteEn
);

  // ==================================================
  // decode
  // ==================================================
  mipsPkg::instr_t instr;
  mipsPkg::ctrl_t  ctrl;

  logic [15:0]                      imm16;
  logic [25:0]                      target;
  logic [mipsPkg::dataWidth-1:0]    immExt;
  logic [mipsPkg::dataWidth-1:0]    rsData;
  logic [mipsPkg::dataWidth-1:0]    rtData;
  logic [mipsPkg::dataWidth-1:0]    aluB;
  logic [mipsPkg::dataWidth-1:0]    aluResult;
  logic                             aluZero;
  logic [mipsPkg::dataWidth-1:0]    pc;
  logic [mipsPkg::dataWidth-1:0]    pcPlus4;
  logic [mipsPkg::regAddrWidth-1:0] wIdx;

  assign instr = mipsPkg::instr_t'(imemData);

  // immediate and target overlay the R-type fields
  assign imm16  = {instr.rd, instr.shamt, instr.funct};
  assign target = {instr.rs, instr.rt, imm16};
  assign immExt = {{(mipsPkg::dataWidth-16){imm16[15]}}, imm16};

  mipsControl uControl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // ==================================================
  // register file and ALU
  // ==================================================
  // rd for R-type, rt for lw, r31 for jal
  assign wIdx = ctrl.link   ? mipsPkg::linkReg :
                ctrl.regDst ? instr.rd         : instr.rt;

  mipsRegFile uRegFile (
    .clk    (clk),
    .rst    (rst),
    .we     (ctrl.regWrite),
    .waddr  (wIdx),
    .raddr1 (instr.rs),
    .raddr2 (instr.rt),
    .wdata  (rfWriteData),
    .rdata1 (rsData),
    .rdata2 (rtData)
  );

  // offset for lw/sw, rt otherwise
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  mipsAlu uAlu (
    .a      (rsData),
    .b      (aluB),
    .op     (ctrl.aluCtrl),
    .result (aluResult),
    .zero   (aluZero)
  );

  mipsPc uPc (
    .clk     (clk),
    .rst     (rst),
    .branch  (ctrl.branch),
    .jump    (ctrl.jump),
    .zero    (aluZero),
    .imm     (immExt),
    .target  (target),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  // ==================================================
  // writeback and memory side
  // ==================================================
  assign rfWriteData = ctrl.link     ? pcPlus4   :
                       ctrl.memToReg ? dmemRData : aluResult;
  assign rfWriteEn   = ctrl.regWrite;

  assign imemAddr  = pc;
  // word address from the byte address
  assign dmemAddr  = aluResult[mipsPkg::dmemAddrWidth+1:2];
  assign dmemWData = rtData;
  // active low strobe
  assign dmemWen   = ~ctrl.memWrite;

endmodule

// ==== sim/mipsClkGen.sv ====
// testbench clock and reset
// 20 ns clock, reset held low for the first 3 cycles

module mipsClkGen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // release just after an edge
  initial begin
    rst = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst = 1'b1;
  end

endmodule

// ==== sim/mipsMem.sv ====
// testbench memories for the MIPS core
// 128-word instruction ROM and 128-word data RAM, both read combinationally

module mipsMem (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [mipsPkg::dataWidth-1:0]     imemAddr,
  output logic [mipsPkg::dataWidth-1:0]     imemData,
  input  logic [mipsPkg::dmemAddrWidth-1:0] dmemAddr,
  input  logic [mipsPkg::dataWidth-1:0]     dmemWData,
  input  logic                              dmemWen,
  output logic [mipsPkg::dataWidth-1:0]     dmemRData
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int numWords = 2 ** mipsPkg::dmemAddrWidth;

  // both arrays are filled from the testbench top at time 0
  logic [mipsPkg::dataWidth-1:0] rom [numWords];
  logic [mipsPkg::dataWidth-1:0] ram [numWords];

  // byte address to word index
  assign imemData  = rom[imemAddr[mipsPkg::dmemAddrWidth+1:2]];
  assign dmemRData = ram[dmemAddr];

  // active low strobe, blocked during reset
  always @(posedge clk) begin
    if (rst && !dmemWen) begin
      ram[dmemAddr] <= dmemWData;
    end
  end

endmodule

// ==== sim/mipsCoreTb.sv ====
// testbench for the single-cycle MIPS core
// directed program plus 40 LFSR instructions, checked every cycle
// against an instruction-set model of registers, data memory and PC

module mipsCoreTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int directedLen  = 21;
  localparam int randomCount  = 40;
  localparam int progLen      = directedLen + randomCount + 1;
  localparam int timeoutLimit = 4 * progLen + 20;
  localparam int numWords     = 2 ** mipsPkg::dmemAddrWidth;

  // expected effect of one instruction
  typedef struct packed {
    logic [mipsPkg::dataWidth-1:0]     pcNext;
    logic                              writeEn;
    logic [mipsPkg::regAddrWidth-1:0]  writeIdx;
    logic [mipsPkg::dataWidth-1:0]     writeData;
    logic                              storeEn;
    logic [mipsPkg::dmemAddrWidth-1:0] storeAddr;
    logic [mipsPkg::dataWidth-1:0]     storeData;
  } expect_t;

  logic                              clk;
  logic                              rst;
  logic [mipsPkg::dataWidth-1:0]     imemAddr;
  logic [mipsPkg::dataWidth-1:0]     imemData;
  logic [mipsPkg::dmemAddrWidth-1:0] dmemAddr;
  logic [mipsPkg::dataWidth-1:0]     dmemWData;
  logic                              dmemWen;
  logic [mipsPkg::dataWidth-1:0]     dmemRData;
  logic [mipsPkg::dataWidth-1:0]     rfWriteData;
  logic                              rfWriteEn;

  // model state
  logic [mipsPkg::dataWidth-1:0] prog      [numWords];
  logic [mipsPkg::dataWidth-1:0] modelRegs [32];
  logic [mipsPkg::dataWidth-1:0] modelRam  [numWords];
  logic [mipsPkg::dataWidth-1:0] modelPc;
  logic [31:0]                   lfsrState;

  int checkCount;
  int valueErrors;
  int strobeErrors;
  int cycles;

  mipsPkg::funct_t fnTable [5] = '{mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd,
                                   mipsPkg::fnOr, mipsPkg::fnSlt};

  mipsClkGen uClk (
    .clk (clk),
    .rst (rst)
  );

  mipsMem uMem (
    .clk       (clk),
    .rst       (rst),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .dmemAddr  (dmemAddr),
    .dmemWData (dmemWData),
    .dmemWen   (dmemWen),
    .dmemRData (dmemRData)
  );

  mipsCore uut (
    .clk         (clk),
    .rst         (rst),
    .imemAddr    (imemAddr),
    .imemData    (imemData),
    .dmemAddr    (dmemAddr),
    .dmemWData   (dmemWData),
    .dmemWen     (dmemWen),
    .dmemRData   (dmemRData),
    .rfWriteData (rfWriteData),
    .rfWriteEn   (rfWriteEn)
  );

  // ==================================================
  // assembler and random source
  // ==================================================
  function automatic logic [31:0] rType(mipsPkg::funct_t fn, logic [4:0] rd,
                                        logic [4:0] rs, logic [4:0] rt);
    mipsPkg::instr_t w;
    w.op    = mipsPkg::opR;
    w.rs    = rs;
    w.rt    = rt;
    w.rd    = rd;
    w.shamt = '0;
    w.funct = fn;
    return w;
  endfunction

  function automatic logic [31:0] iType(mipsPkg::opcode_t op, logic [4:0] rt,
                                        logic [4:0] rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // target is a word index
  function automatic logic [31:0] jType(mipsPkg::opcode_t op, int target);
    return {op, 26'(target)};
  endfunction

  // whole-address fill, mixes signs
  function automatic logic [31:0] ramFill(int idx);
    return 32'h9e3779b9 * 32'(idx + 1);
  endfunction

  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  // ==================================================
  // reference model
  // ==================================================
  function automatic expect_t refStep(logic [31:0] word);
    mipsPkg::instr_t ins;
    expect_t         e;
    logic [31:0]     rsVal;
    logic [31:0]     rtVal;
    logic [31:0]     immExt;
    logic [31:0]     pcPlus4;
    logic [31:0]     addr;
    ins     = mipsPkg::instr_t'(word);
    rsVal   = modelRegs[ins.rs];
    rtVal   = modelRegs[ins.rt];
    immExt  = {{16{word[15]}}, word[15:0]};
    pcPlus4 = modelPc + 32'd4;
    addr    = rsVal + immExt;
    e        = '0;
    e.pcNext = pcPlus4;
    case (ins.op)
      mipsPkg::opR: begin
        e.writeEn  = 1'b1;
        e.writeIdx = ins.rd;
        case (ins.funct)
          mipsPkg::fnAdd: e.writeData = rsVal + rtVal;
          mipsPkg::fnSub: e.writeData = rsVal - rtVal;
          mipsPkg::fnAnd: e.writeData = rsVal & rtVal;
          mipsPkg::fnOr:  e.writeData = rsVal | rtVal;
          mipsPkg::fnSlt: e.writeData = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
          default:        e.writeEn = 1'b0;
        endcase
      end
      mipsPkg::opLw: begin
        e.writeEn   = 1'b1;
        e.writeIdx  = ins.rt;
        e.writeData = modelRam[addr[8:2]];
      end
      mipsPkg::opSw: begin
        e.storeEn   = 1'b1;
        e.storeAddr = addr[8:2];
        e.storeData = rtVal;
      end
      mipsPkg::opBeq: begin
        if (rsVal == rtVal) begin
          e.pcNext = pcPlus4 + {immExt[29:0], 2'b00};
        end
      end
      mipsPkg::opJ: begin
        e.pcNext = {pcPlus4[31:28], word[25:0], 2'b00};
      end
      mipsPkg::opJal: begin
        e.pcNext    = {pcPlus4[31:28], word[25:0], 2'b00};
        e.writeEn   = 1'b1;
        e.writeIdx  = 5'd31;
        e.writeData = pcPlus4;
      end
      default: begin
      end
    endcase
    return e;
  endfunction

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic checkValue(string name, logic [mipsPkg::dataWidth-1:0] expected,
                            logic [mipsPkg::dataWidth-1:0] actual);
    checkCount++;
    if (actual !== expected) begin
      valueErrors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkStrobe(string name, logic expected, logic actual);
    checkCount++;
    if (actual !== expected) begin
      strobeErrors++;
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // ==================================================
  // program and memory setup, before reset ends
  // ==================================================
  initial begin : build
    int               i;
    int               fnSel;
    logic [31:0]      kind;
    logic [4:0]       rd;
    logic [4:0]       rs;
    logic [4:0]       rt;
    mipsPkg::opcode_t memOp;
    lfsrState    = 32'ha38cd438;
    modelPc      = '0;
    checkCount   = 0;
    valueErrors  = 0;
    strobeErrors = 0;
    for (i = 0; i < numWords; i++) begin
      prog[i]     = '0;
      modelRam[i] = ramFill(i);
      uMem.ram[i] = ramFill(i);
    end
    for (i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end
    // operands from the RAM fill, r1 is negative
    prog[0]  = iType(mipsPkg::opLw, 5'd1, 5'd0, 16'd0);
    prog[1]  = iType(mipsPkg::opLw, 5'd2, 5'd0, 16'd4);
    prog[2]  = iType(mipsPkg::opLw, 5'd3, 5'd0, 16'd8);
    prog[3]  = rType(mipsPkg::fnAdd, 5'd4, 5'd1, 5'd2);
    prog[4]  = rType(mipsPkg::fnSub, 5'd5, 5'd1, 5'd2);
    prog[5]  = rType(mipsPkg::fnAnd, 5'd6, 5'd1, 5'd3);
    prog[6]  = rType(mipsPkg::fnOr,  5'd7, 5'd2, 5'd3);
    prog[7]  = rType(mipsPkg::fnSlt, 5'd8, 5'd1, 5'd2);
    prog[8]  = rType(mipsPkg::fnSlt, 5'd9, 5'd2, 5'd1);
    // store then load back
    prog[9]  = iType(mipsPkg::opSw, 5'd4, 5'd0, 16'd40);
    prog[10] = iType(mipsPkg::opLw, 5'd10, 5'd0, 16'd40);
    // beq taken over 12, then not taken
    prog[11] = iType(mipsPkg::opBeq, 5'd1, 5'd1, 16'd1);
    prog[12] = rType(mipsPkg::fnAdd, 5'd11, 5'd1, 5'd1);
    prog[13] = iType(mipsPkg::opBeq, 5'd2, 5'd1, 16'd1);
    // r0 write dropped, r12 must equal r3
    prog[14] = rType(mipsPkg::fnAdd, 5'd0, 5'd1, 5'd2);
    prog[15] = rType(mipsPkg::fnAdd, 5'd12, 5'd0, 5'd3);
    // jal over 17, r31 read back into r13
    prog[16] = jType(mipsPkg::opJal, 18);
    prog[17] = rType(mipsPkg::fnAdd, 5'd11, 5'd2, 5'd2);
    prog[18] = rType(mipsPkg::fnAdd, 5'd13, 5'd31, 5'd0);
    prog[19] = jType(mipsPkg::opJ, 21);
    prog[20] = rType(mipsPkg::fnAdd, 5'd11, 5'd3, 5'd3);
    // random R-type and lw/sw, r0 base keeps addresses in range
    for (i = 0; i < randomCount; i++) begin
      kind = randBits(2);
      if (kind < 2) begin
        fnSel = int'(randBits(3) % 5);
        rd    = 5'(randBits(5));
        rs    = 5'(randBits(5));
        rt    = 5'(randBits(5));
        prog[directedLen + i] = rType(fnTable[fnSel], rd, rs, rt);
      end else begin
        if (kind == 2) begin
          memOp = mipsPkg::opLw;
        end else begin
          memOp = mipsPkg::opSw;
        end
        rt = 5'(randBits(5));
        prog[directedLen + i] = iType(memOp, rt, 5'd0, {7'd0, 7'(randBits(7)), 2'b00});
      end
    end
    // final loop
    prog[progLen - 1] = jType(mipsPkg::opJ, progLen - 1);
    for (i = 0; i < numWords; i++) begin
      uMem.rom[i] = prog[i];
    end
  end

  // ==================================================
  // per-cycle compare
  // ==================================================
  initial begin : compare
    expect_t     want;
    logic        reached;
    string       tag;
    @(posedge rst);
    #1;
    reached = 1'b0;
    while (!reached) begin
      tag = (modelPc < 4 * directedLen) ? "directed" : "random";
      tag = $sformatf("%s pc=%0h", tag, modelPc);
      checkValue({tag, " imemAddr"}, modelPc, imemAddr);
      want = refStep(prog[modelPc[8:2]]);
      checkStrobe({tag, " rfWriteEn"}, want.writeEn, rfWriteEn);
      if (want.writeEn) begin
        checkValue({tag, " rfWriteData"}, want.writeData, rfWriteData);
      end
      checkStrobe({tag, " dmemWen"}, ~want.storeEn, dmemWen);
      if (want.storeEn) begin
        checkValue({tag, " dmemAddr"}, 32'(want.storeAddr), 32'(dmemAddr));
        checkValue({tag, " dmemWData"}, want.storeData, dmemWData);
      end
      // commit to the model
      if (want.writeEn && (want.writeIdx != '0)) begin
        modelRegs[want.writeIdx] = want.writeData;
      end
      if (want.storeEn) begin
        modelRam[want.storeAddr] = want.storeData;
      end
      // a jump to itself ends the program
      reached = (want.pcNext == modelPc);
      modelPc = want.pcNext;
      @(posedge clk);
      #2;
    end
    checkValue("final loop imemAddr", modelPc, imemAddr);
    $display("checks %0d, value errors %0d, strobe errors %0d",
             checkCount, valueErrors, strobeErrors);
    if (valueErrors == 0 && strobeErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // run limit from the program length
  initial begin : watchdog
    cycles = 0;
    while (cycles < timeoutLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the core did not reach the final loop", cycles);
    $display("checks %0d, value errors %0d, strobe errors %0d",
             checkCount, valueErrors, strobeErrors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/mipsPkg.sv
hw/mipsControl.sv
hw/mipsAlu.sv
hw/mipsRegFile.sv
hw/mipsPc.sv
hw/mipsCore.sv
sim/mipsClkGen.sv
sim/mipsMem.sv
sim/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipscore

sources:
  # RTL in compile order
  - files:
      - hw/mipsPkg.sv
      - hw/mipsControl.sv
      - hw/mipsAlu.sv
      - hw/mipsRegFile.sv
      - hw/mipsPc.sv
      - hw/mipsCore.sv
  # testbench
  - target: simulation
    files:
      - sim/mipsClkGen.sv
      - sim/mipsMem.sv
      - sim/mipsCoreTb.sv
